// File: Makefile
VERILATOR  ?= verilator
TOP        := swu_tb
FILELIST   := swu.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/10ps -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/10ps -Wall
SIM_ARGS   := +verilator+error+limit+100

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/swu_properties.sv
`timescale 1ns/10ps

module swu_properties import swu_geom_pkg::*, swu_types_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input addr_t ram_addr,
    input logic  ram_rd,
    input logic  pe_en,
    input logic  busy,
    input logic  done
);

    typedef logic [ADDR_W:0] rd_cnt_t;

    rd_cnt_t rd_count;
    logic    reset_bad    = 1'b0;
    logic    order_bad    = 1'b0;
    logic    extra_bad    = 1'b0;
    logic    total_bad    = 1'b0;
    logic    handover_bad = 1'b0;
    logic    hold_bad     = 1'b0;
    logic    quiet_bad    = 1'b0;
    logic    any_fail;

    assign any_fail = reset_bad | order_bad | extra_bad | total_bad |
                      handover_bad | hold_bad | quiet_bad;

    // Reads seen so far, also the address expected next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_count <= '0;
        end else if (ram_rd) begin
            rd_count <= rd_count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Reset and read order
    ////////////////////////////////////////

    reset_quiet_a: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!pe_en && !busy && !done))
    else begin
        reset_bad = 1'b1;
        $error("pe_en, busy or done set during reset or just after it");
    end

    read_order_a: assert property (@(posedge clk) disable iff (!rst_n)
        ram_rd |-> ({1'b0, ram_addr} == rd_count))
    else begin
        order_bad = 1'b1;
        $error("RAM read address out of order: %0d, expected %0d", ram_addr, rd_count);
    end

    read_limit_a: assert property (@(posedge clk) disable iff (!rst_n)
        ram_rd |-> (rd_count < rd_cnt_t'(NUM_WORDS)))
    else begin
        extra_bad = 1'b1;
        $error("More RAM reads than words in a row");
    end

    read_total_a: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (rd_count == rd_cnt_t'(NUM_WORDS)))
    else begin
        total_bad = 1'b1;
        $error("Run finished after %0d RAM reads", rd_count);
    end

    ////////////////////////////////////////
    // Completion
    ////////////////////////////////////////

    busy_handover_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $fell(busy))
    else begin
        handover_bad = 1'b1;
        $error("busy did not fall in the cycle done rose");
    end

    done_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> done)
    else begin
        hold_bad = 1'b1;
        $error("done dropped before reset");
    end

    // Nothing moves once the run is over
    done_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (!busy && !pe_en && !ram_rd))
    else begin
        quiet_bad = 1'b1;
        $error("busy, pe_en or ram_rd active after done");
    end

endmodule

// File: bench/swu_tb.sv
`timescale 1ns/10ps

module swu_tb import swu_geom_pkg::*, swu_types_pkg::*;;

    localparam int          CLK_PERIOD      = 100;
    localparam logic [31:0] LFSR_SEED       = 32'h9e3b;
    localparam logic [31:0] LFSR_TAPS       = 32'h80200003;
    localparam int          WATCHDOG_CYCLES = 2 * (STREAM_LEN + RD_LAT + 20);

    logic        clk = 1'b0;
    logic        rst_n;
    ram_row_t    ram_data;
    addr_t       ram_addr;
    logic        ram_rd;
    window_vec_t windows;
    logic        pe_en;
    logic        busy;
    logic        done;

    ram_row_t              mem [NUM_WORDS];
    logic [STREAM_LEN-1:0] stream_bits [NUM_LANES];
    logic                  rd_d1        = 1'b0;
    addr_t                 addr_d1      = '0;
    int                    win_cnt      = 0;
    logic                  win_run_over = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    swu_top swu_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ram_data (ram_data),
        .ram_addr (ram_addr),
        .ram_rd   (ram_rd),
        .windows  (windows),
        .pe_en    (pe_en),
        .busy     (busy),
        .done     (done)
    );

    bind swu_top swu_properties props_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ram_addr (ram_addr),
        .ram_rd   (ram_rd),
        .pe_en    (pe_en),
        .busy     (busy),
        .done     (done)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per stored bit
    task automatic fill_ram();
        logic [31:0] state;
        state = LFSR_SEED;
        for (int row = 0; row < NUM_WORDS; row++) begin
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                for (int b = 0; b < WORD_W; b++) begin
                    state = lfsr_step(state);
                    mem[row][lane][b] = state[0];
                end
            end
        end
    endtask

    // Bit 0 is the first bit into the window
    task automatic build_streams();
        int pos_in_row;
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            for (int pos = 0; pos < STREAM_LEN; pos++) begin
                if (pos < PAD_LEN || pos >= STREAM_LEN - PAD_LEN) begin
                    stream_bits[lane][pos] = 1'b1;
                end else begin
                    pos_in_row = pos - PAD_LEN;
                    stream_bits[lane][pos] =
                        mem[pos_in_row / WORD_W][lane][WORD_W - 1 - pos_in_row % WORD_W];
                end
            end
        end
    endtask

    function automatic window_t expected_window(input int lane, input int k);
        window_t win;
        for (int j = 0; j < WIN_W; j++) begin
            win[WIN_W - 1 - j] = stream_bits[lane][k + j];
        end
        return win;
    endfunction

    task automatic report_failure();
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // RAM with two cycles of read latency and no data hold
    always @(posedge clk) begin
        rd_d1   <= ram_rd;
        addr_d1 <= ram_addr;
        if (rd_d1) begin
            ram_data <= mem[addr_d1];
        end else begin
            ram_data <= 'x;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    always @(negedge clk) begin : check_windows
        window_t exp_win;
        if (pe_en) begin
            assert (!win_run_over) else begin
                $display("pe_en came back after the window run had ended");
                report_failure();
            end
            assert (win_cnt < NUM_WINDOWS) else begin
                $display("CHECK FAILED window_count expected at most %0d actual %0d",
                         NUM_WINDOWS, win_cnt + 1);
                report_failure();
            end
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                exp_win = expected_window(lane, win_cnt);
                assert (windows[lane] == exp_win) else begin
                    $display("CHECK FAILED window_content lane %0d window %0d expected %b actual %b",
                             lane, win_cnt, exp_win, windows[lane]);
                    report_failure();
                end
            end
            win_cnt++;
        end else if (win_cnt > 0) begin
            win_run_over = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (swu_top_inst.props_inst.any_fail) begin
            $display("A protocol property bound to the DUT failed");
            report_failure();
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: done did not rise within %0d cycles", WATCHDOG_CYCLES);
        report_failure();
    end

    initial begin : stimulus
        rst_n    <= 1'b0;
        ram_data = '0;
        fill_ram();
        build_streams();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        // A few idle cycles for the completion properties
        repeat (4) @(negedge clk);
        assert (win_cnt == NUM_WINDOWS) else begin
            $display("CHECK FAILED window_count expected %0d actual %0d", NUM_WINDOWS, win_cnt);
            report_failure();
        end
        if (swu_top_inst.props_inst.any_fail) begin
            report_failure();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: swu.f
verilog/swu_geom_pkg.sv
verilog/swu_types_pkg.sv
verilog/swu_word_sched.sv
verilog/swu_lane.sv
verilog/swu_window_out.sv
verilog/swu_top.sv
bench/swu_properties.sv
bench/swu_tb.sv

// File: verilog/swu_geom_pkg.sv
package swu_geom_pkg;

    // Array geometry
    localparam int NUM_LANES = 16;
    localparam int WORD_W    = 32;
    localparam int NUM_WORDS = 15;

    // Window and framing
    localparam int WIN_W   = 7;
    localparam int PAD_LEN = 5;

    // External RAM
    localparam int RD_LAT = 2;
    localparam int ADDR_W = $clog2(NUM_WORDS);

    ////////////////////////////////////////
    // Derived stream lengths
    ////////////////////////////////////////

    // 5 pad + 480 row bits + 5 pad
    localparam int STREAM_LEN = 2 * PAD_LEN + NUM_WORDS * WORD_W;

    localparam int NUM_WINDOWS = STREAM_LEN - WIN_W + 1;

endpackage

// File: verilog/swu_lane.sv
`timescale 1ns/10ps

module swu_lane import swu_geom_pkg::*, swu_types_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lane_ctl_t  lane_ctl,
    input  lane_word_t word_in,
    output window_t    window
);

    typedef logic [$clog2(WORD_W + 1)-1:0] bit_left_t;

    lane_word_t nxt_word;
    lane_word_t cur_word;
    bit_left_t  cur_left;
    logic       cur_empty;
    logic       cur_last;
    logic       row_shift;
    logic       new_bit;

    assign cur_empty = (cur_left == '0);
    assign cur_last  = (cur_left == bit_left_t'(1));
    assign row_shift = lane_ctl.shift && !lane_ctl.use_pad;

    // Pad ones or row bits MSB first
    assign new_bit = lane_ctl.use_pad ? 1'b1 : cur_word[WORD_W-1];

    ////////////////////////////////////////
    // Bit bookkeeping and window
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_left <= '0;
            window   <= '0;
        end else begin
            if (lane_ctl.load_next && cur_empty) begin
                cur_left <= bit_left_t'(WORD_W);
            end else if (row_shift) begin
                // Prefetched word takes over as the last bit leaves
                cur_left <= cur_last ? bit_left_t'(WORD_W) : cur_left - 1'b1;
            end
            if (lane_ctl.shift) begin
                window <= {window[WIN_W-2:0], new_bit};
            end
        end
    end

    ////////////////////////////////////////
    // Word buffers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        // First word goes straight to the shifter
        if (lane_ctl.load_next && cur_empty) begin
            cur_word <= word_in;
        end else if (row_shift) begin
            cur_word <= cur_last ? nxt_word : {cur_word[WORD_W-2:0], 1'b0};
        end

        if (lane_ctl.load_next && !cur_empty) begin
            nxt_word <= word_in;
        end
    end

endmodule

// File: verilog/swu_top.sv
`timescale 1ns/10ps

module swu_top import swu_geom_pkg::*, swu_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ram_row_t    ram_data,
    output addr_t       ram_addr,
    output logic        ram_rd,
    output window_vec_t windows,
    output logic        pe_en,
    output logic        busy,
    output logic        done
);

    lane_ctl_t   lane_ctl;
    logic        first_win;
    logic        last_win;
    window_vec_t lane_windows;

    swu_word_sched sched_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_addr  (ram_addr),
        .ram_rd    (ram_rd),
        .lane_ctl  (lane_ctl),
        .first_win (first_win),
        .last_win  (last_win)
    );

    ////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        swu_lane lane_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .lane_ctl (lane_ctl),
            .word_in  (ram_data[i]),
            .window   (lane_windows[i])
        );
    end

    swu_window_out out_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_ctl     (lane_ctl),
        .first_win    (first_win),
        .last_win     (last_win),
        .lane_windows (lane_windows),
        .windows      (windows),
        .pe_en        (pe_en),
        .busy         (busy),
        .done         (done)
    );

endmodule

// File: verilog/swu_types_pkg.sv
package swu_types_pkg;

    import swu_geom_pkg::*;

    // RAM side
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [WORD_W-1:0] lane_word_t;

    // One column per lane, lane i at slice i
    typedef logic [NUM_LANES-1:0][WORD_W-1:0] ram_row_t;

    ////////////////////////////////////////
    // Broadcast lane control
    ////////////////////////////////////////

    typedef struct packed {
        logic load_next;
        logic shift;
        logic use_pad;
        logic win_ok;
    } lane_ctl_t;

    // Oldest stream bit sits in the MSB
    typedef logic [WIN_W-1:0] window_t;

    typedef logic [NUM_LANES-1:0][WIN_W-1:0] window_vec_t;

endpackage

// File: verilog/swu_window_out.sv
`timescale 1ns/10ps

module swu_window_out import swu_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  lane_ctl_t   lane_ctl,
    input  logic        first_win,
    input  logic        last_win,
    input  window_vec_t lane_windows,
    output window_vec_t windows,
    output logic        pe_en,
    output logic        busy,
    output logic        done
);

    logic       shift_d;
    logic       win_ok_d;
    logic [1:0] last_d;

    // Lane windows trail the control by one cycle, outputs by two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_d  <= 1'b0;
            win_ok_d <= 1'b0;
            last_d   <= '0;
            windows  <= '0;
            pe_en    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            shift_d  <= lane_ctl.shift;
            win_ok_d <= lane_ctl.win_ok;
            last_d   <= {last_d[0], last_win};
            pe_en    <= win_ok_d;
            if (shift_d) begin
                windows <= lane_windows;
            end
            if (first_win) begin
                busy <= 1'b1;
            end
            // Drop busy once the last window has been presented
            if (last_d[1]) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/swu_word_sched.sv
`timescale 1ns/10ps

module swu_word_sched import swu_geom_pkg::*, swu_types_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output addr_t     ram_addr,
    output logic      ram_rd,
    output lane_ctl_t lane_ctl,
    output logic      first_win,
    output logic      last_win
);

    typedef enum logic [1:0] {
        PH_HEAD,
        PH_ROW,
        PH_TAIL,
        PH_FIN
    } phase_t;

    typedef logic [$clog2(STREAM_LEN)-1:0] bit_cnt_t;
    typedef logic [$clog2(WORD_W)-1:0]     gap_cnt_t;

    phase_t            phase;
    phase_t            phase_nxt;
    logic              started;
    bit_cnt_t          bit_cnt;
    gap_cnt_t          gap_cnt;
    logic [RD_LAT-1:0] rd_pipe;
    logic              shift;

    ////////////////////////////////////////
    // RAM reads
    ////////////////////////////////////////

    // Word 0 on the first clock, then one word every WORD_W cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started  <= 1'b0;
            ram_rd   <= 1'b0;
            ram_addr <= '0;
            gap_cnt  <= '0;
        end else begin
            started <= 1'b1;
            ram_rd  <= !started;
            if (started) begin
                gap_cnt <= gap_cnt + 1'b1;
                if (gap_cnt == gap_cnt_t'(WORD_W - 1) &&
                    ram_addr != addr_t'(NUM_WORDS - 1)) begin
                    ram_rd   <= 1'b1;
                    ram_addr <= ram_addr + 1'b1;
                end
            end
        end
    end

    // Read data lands RD_LAT cycles after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= {rd_pipe[RD_LAT-2:0], ram_rd};
        end
    end

    ////////////////////////////////////////
    // Stream phases
    ////////////////////////////////////////

    assign shift = started && (phase != PH_FIN);

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_HEAD: if (bit_cnt == bit_cnt_t'(PAD_LEN - 1)) phase_nxt = PH_ROW;
            PH_ROW:  if (bit_cnt == bit_cnt_t'(STREAM_LEN - PAD_LEN - 1)) phase_nxt = PH_TAIL;
            PH_TAIL: if (bit_cnt == bit_cnt_t'(STREAM_LEN - 1)) phase_nxt = PH_FIN;
            default: phase_nxt = PH_FIN;
        endcase
    end

    // bit_cnt holds the number of shifts already done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_HEAD;
            bit_cnt <= '0;
        end else begin
            phase <= phase_nxt;
            if (shift) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        lane_ctl.load_next = rd_pipe[RD_LAT-1];
        lane_ctl.shift     = shift;
        lane_ctl.use_pad   = (phase != PH_ROW);
        // Window is full from the seventh shift on
        lane_ctl.win_ok    = shift && (bit_cnt >= bit_cnt_t'(WIN_W - 1));
    end

    // Run start, one cycle ahead of the first read strobe
    assign first_win = !started;
    assign last_win  = shift && (bit_cnt == bit_cnt_t'(STREAM_LEN - 1));

endmodule
